/* rtl/scope_pkg.sv */
package scope_pkg;

   // ADC sample format
   localparam int SAMPLE_W = 12;
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // Largest downsample exponent, a factor of 16
   localparam int DS_MAX = 4;
   typedef logic [2:0] ds_t;

   // Accumulator holds the sum of 2^DS_MAX samples without overflow
   localparam int ACC_W = SAMPLE_W + DS_MAX;

   typedef logic [7:0] tot_t;
   typedef logic [31:0] evcount_t;

   typedef enum logic [2:0] {
      acq_idle,
      acq_prefill,
      acq_armed,
      acq_postfill,
      acq_done
   } acq_state_e;

   typedef enum logic {
      trig_rising,
      trig_falling
   } trig_type_e;

endpackage

/* rtl/trig_cfg_if.sv */
`timescale 1ns/1ps

interface trig_cfg_if;
   import scope_pkg::*;

   sample_t    lower_thresh;
   sample_t    upper_thresh;
   trig_type_e trig_type;
   tot_t       trig_tot;

   // Held stable by the driver while an acquisition is running
   modport src (
      output lower_thresh,
      output upper_thresh,
      output trig_type,
      output trig_tot
   );

   modport sink (
      input lower_thresh,
      input upper_thresh,
      input trig_type,
      input trig_tot
   );

endinterface

/* rtl/sample_downsampler.sv */
`timescale 1ns/1ps

module sample_downsampler (
   input  logic               lvds_clk_slow_clkin,
   input  logic               rst_n,
   input  scope_pkg::sample_t adc_sample,
   input  scope_pkg::ds_t     downsample,
   input  logic               highres,
   output scope_pkg::sample_t ds_sample,
   output logic               ds_valid
);
   import scope_pkg::*;

   ds_t                     n_eff;
   logic [DS_MAX-1:0]       grp_cnt;
   logic [DS_MAX-1:0]       grp_mask;
   logic                    grp_first;
   logic                    grp_last;
   logic signed [ACC_W-1:0] acc;
   logic signed [ACC_W-1:0] acc_next;
   logic signed [ACC_W-1:0] avg;
   sample_t                 first_q;
   sample_t                 first_sample;

   // Exponent clamped to the largest supported factor
   assign n_eff = (downsample > ds_t'(DS_MAX)) ? ds_t'(DS_MAX) : downsample;

   // Free-running counter, the low n bits give the position inside a group
   assign grp_mask  = ~({DS_MAX{1'b1}} << n_eff);
   assign grp_first = (grp_cnt & grp_mask) == '0;
   assign grp_last  = (grp_cnt & grp_mask) == grp_mask;

   // Running sum restarts on the first input of each group
   assign acc_next = (grp_first ? '0 : acc)
                   + {{DS_MAX{adc_sample[SAMPLE_W-1]}}, adc_sample};

   // Power-of-two average, arithmetic shift keeps the sign
   assign avg = acc_next >>> n_eff;

   // Decimation keeps the first input of the group
   assign first_sample = grp_first ? adc_sample : first_q;

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         grp_cnt  <= '0;
         ds_valid <= 1'b0;
      end else begin
         grp_cnt  <= grp_cnt + DS_MAX'(1);
         ds_valid <= grp_last;
      end
   end

   always_ff @(posedge lvds_clk_slow_clkin) begin
      acc <= acc_next;
      if (grp_first) begin
         first_q <= adc_sample;
      end
      if (grp_last) begin
         ds_sample <= highres ? avg[SAMPLE_W-1:0] : first_sample;
      end
   end

   // With a fixed nonzero exponent output strobes are spaced apart
   a_ds_spacing: assert property (
      @(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      ds_valid && (n_eff != '0) && $stable(n_eff) |=> !ds_valid
   );

endmodule

/* rtl/trigger_detector.sv */
`timescale 1ns/1ps

module trigger_detector (
   input  logic               lvds_clk_slow_clkin,
   input  logic               rst_n,
   trig_cfg_if.sink           cfg,
   input  scope_pkg::sample_t ds_sample,
   input  logic               ds_valid,
   input  logic               det_enable,
   output logic               trig
);
   import scope_pkg::*;

   logic armed;
   tot_t run_cnt;
   tot_t tot_eff;
   logic arm_hit;
   logic run_hit;
   logic run_done;

   // A zero time-over-threshold behaves like one sample
   assign tot_eff = (cfg.trig_tot == '0) ? tot_t'(1) : cfg.trig_tot;

   // Hysteresis, arm on one threshold and count beyond the other
   always_comb begin
      if (cfg.trig_type == trig_falling) begin
         arm_hit = ds_sample >= cfg.upper_thresh;
         run_hit = ds_sample <= cfg.lower_thresh;
      end else begin
         arm_hit = ds_sample <= cfg.lower_thresh;
         run_hit = ds_sample >= cfg.upper_thresh;
      end
   end

   // This qualifying sample completes the run
   assign run_done = run_cnt >= (tot_eff - tot_t'(1));

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         armed   <= 1'b0;
         run_cnt <= '0;
         trig    <= 1'b0;
      end else begin
         trig <= 1'b0;
         if (!det_enable) begin
            armed   <= 1'b0;
            run_cnt <= '0;
         end else if (ds_valid) begin
            if (!armed) begin
               armed   <= arm_hit;
               run_cnt <= '0;
            end else if (!run_hit) begin
               // Run broken, start counting again
               run_cnt <= '0;
            end else if (run_done) begin
               trig    <= 1'b1;
               armed   <= 1'b0;
               run_cnt <= '0;
            end else begin
               run_cnt <= run_cnt + tot_t'(1);
            end
         end
      end
   end

   // The controller must still be searching when the pulse arrives
   a_trig_enabled: assert property (
      @(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      trig |-> det_enable
   );

endmodule

/* rtl/acq_controller.sv */
`timescale 1ns/1ps

module acq_controller #(
   parameter int ADDR_W = 10
) (
   input  logic                  lvds_clk_slow_clkin,
   input  logic                  rst_n,
   input  logic                  ds_valid,
   input  logic                  trig,
   input  logic                  arm,
   input  logic                  readout_done,
   input  logic [ADDR_W-1:0]     pre_length,
   input  logic [ADDR_W-1:0]     post_length,
   output logic                  ram_we,
   output logic [ADDR_W-1:0]     ram_waddr,
   output logic                  det_enable,
   output scope_pkg::acq_state_e acq_state,
   output logic [ADDR_W-1:0]     trig_addr,
   output scope_pkg::evcount_t   event_count
);
   import scope_pkg::*;

   acq_state_e        state;
   acq_state_e        state_next;
   logic [ADDR_W-1:0] wptr;
   logic [ADDR_W-1:0] seg_cnt;
   logic [ADDR_W-1:0] seg_base;
   logic [ADDR_W-1:0] seg_len;
   logic [ADDR_W-1:0] seg_next;
   logic              trig_hit;
   logic              recording;
   logic              counting;
   logic              seg_full;
   logic              seg_end;

   assign trig_hit  = (state == acq_armed) && trig;
   assign recording = state inside {acq_prefill, acq_armed, acq_postfill};

   // One counter serves the pre-fill and the post-fill segment
   // A write in the trigger cycle already belongs to the post-fill
   assign counting = (state == acq_prefill) || (state == acq_postfill) || trig_hit;
   assign seg_len  = (state == acq_prefill) ? pre_length : post_length;
   assign seg_base = (state == acq_armed) ? '0 : seg_cnt;
   assign seg_full = counting && (seg_base == seg_len);

   // Samples outside a recording state are dropped
   assign ram_we   = ds_valid && recording && !seg_full;
   assign seg_next = seg_base + ADDR_W'(ram_we);
   assign seg_end  = counting && (seg_next == seg_len);

   assign ram_waddr  = wptr;
   assign det_enable = (state == acq_armed);
   assign acq_state  = state;

   always_comb begin
      state_next = state;
      unique case (state)
         acq_idle: begin
            if (arm) begin
               state_next = acq_prefill;
            end
         end
         acq_prefill: begin
            if (seg_end) begin
               state_next = acq_armed;
            end
         end
         acq_armed: begin
            if (trig_hit) begin
               state_next = seg_end ? acq_done : acq_postfill;
            end
         end
         acq_postfill: begin
            if (seg_end) begin
               state_next = acq_done;
            end
         end
         acq_done: begin
            if (readout_done) begin
               state_next = acq_idle;
            end
         end
         default: state_next = acq_idle;
      endcase
   end

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         state       <= acq_idle;
         wptr        <= '0;
         seg_cnt     <= '0;
         trig_addr   <= '0;
         event_count <= '0;
      end else begin
         state   <= state_next;
         seg_cnt <= (counting && !seg_end) ? seg_next : '0;
         // Ring pointer wraps at the memory size
         if (ram_we) begin
            wptr <= wptr + ADDR_W'(1);
         end
         // Triggering sample was written one cycle before the pulse
         if (trig_hit) begin
            trig_addr   <= wptr - ADDR_W'(1);
            event_count <= event_count + 32'd1;
         end
      end
   end

   // No sample is written while idle or done, so the ring pointer holds
   a_no_write_outside_record: assert property (
      @(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      (state == acq_idle || state == acq_done) |=> $stable(wptr)
   );

endmodule

/* rtl/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram #(
   parameter int ADDR_W = 10
) (
   input  logic               lvds_clk_slow_clkin,
   input  logic               ram_we,
   input  logic [ADDR_W-1:0]  ram_waddr,
   input  scope_pkg::sample_t wr_data,
   input  logic [ADDR_W-1:0]  rd_addr,
   output scope_pkg::sample_t rd_data
);
   import scope_pkg::*;

   // One word per reduced sample
   sample_t mem [2**ADDR_W];

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (ram_we) begin
         mem[ram_waddr] <= wr_data;
      end
   end

   // Registered read port, old data on a same-address write
   always_ff @(posedge lvds_clk_slow_clkin) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* rtl/scope_top.sv */
`timescale 1ns/1ps

module scope_top #(
   parameter int ADDR_W = 10
) (
   input  logic                  lvds_clk_slow_clkin,
   input  logic                  rst_n,
   input  scope_pkg::sample_t    adc_sample,
   input  scope_pkg::ds_t        downsample,
   input  logic                  highres,
   input  scope_pkg::sample_t    lower_thresh,
   input  scope_pkg::sample_t    upper_thresh,
   input  scope_pkg::trig_type_e trig_type,
   input  scope_pkg::tot_t       trig_tot,
   input  logic [ADDR_W-1:0]     pre_length,
   input  logic [ADDR_W-1:0]     post_length,
   input  logic                  arm,
   input  logic                  readout_done,
   input  logic [ADDR_W-1:0]     rd_addr,
   output scope_pkg::sample_t    rd_data,
   output scope_pkg::acq_state_e acq_state,
   output logic [ADDR_W-1:0]     trig_addr,
   output scope_pkg::evcount_t   event_count
);
   import scope_pkg::*;

   sample_t           ds_sample;
   logic              ds_valid;
   logic              trig;
   logic              ram_we;
   logic [ADDR_W-1:0] ram_waddr;
   logic              det_enable;

   // Trigger configuration bundle, driven from the top ports
   trig_cfg_if cfg_if ();

   assign cfg_if.lower_thresh = lower_thresh;
   assign cfg_if.upper_thresh = upper_thresh;
   assign cfg_if.trig_type    = trig_type;
   assign cfg_if.trig_tot     = trig_tot;

   sample_downsampler u_downsampler (
      .lvds_clk_slow_clkin (lvds_clk_slow_clkin),
      .rst_n               (rst_n),
      .adc_sample          (adc_sample),
      .downsample          (downsample),
      .highres             (highres),
      .ds_sample           (ds_sample),
      .ds_valid            (ds_valid)
   );

   trigger_detector u_trigger (
      .lvds_clk_slow_clkin (lvds_clk_slow_clkin),
      .rst_n               (rst_n),
      .cfg                 (cfg_if.sink),
      .ds_sample           (ds_sample),
      .ds_valid            (ds_valid),
      .det_enable          (det_enable),
      .trig                (trig)
   );

   acq_controller #(
      .ADDR_W (ADDR_W)
   ) u_acq (
      .lvds_clk_slow_clkin (lvds_clk_slow_clkin),
      .rst_n               (rst_n),
      .ds_valid            (ds_valid),
      .trig                (trig),
      .arm                 (arm),
      .readout_done        (readout_done),
      .pre_length          (pre_length),
      .post_length         (post_length),
      .ram_we              (ram_we),
      .ram_waddr           (ram_waddr),
      .det_enable          (det_enable),
      .acq_state           (acq_state),
      .trig_addr           (trig_addr),
      .event_count         (event_count)
   );

   // Reduced samples go straight into the ring buffer
   sample_ram #(
      .ADDR_W (ADDR_W)
   ) u_ram (
      .lvds_clk_slow_clkin (lvds_clk_slow_clkin),
      .ram_we              (ram_we),
      .ram_waddr           (ram_waddr),
      .wr_data             (ds_sample),
      .rd_addr             (rd_addr),
      .rd_data             (rd_data)
   );

endmodule

/* dv/scope_tb.sv */
`timescale 1ns/1ps

module scope_tb;
   import scope_pkg::*;

   localparam int ADDR_W = 6;
   localparam int DEPTH  = 2 ** ADDR_W;
   // Three acquisitions of up to 64 samples at factor 16 plus readout, with margin
   localparam int TIMEOUT_CYCLES = 20000;

   logic              lvds_clk_slow_clkin = 1'b0;
   logic              rst_n;
   sample_t           adc_sample;
   ds_t               downsample;
   logic              highres;
   sample_t           lower_thresh;
   sample_t           upper_thresh;
   trig_type_e        trig_type;
   tot_t              trig_tot;
   logic [ADDR_W-1:0] pre_length;
   logic [ADDR_W-1:0] post_length;
   logic              arm;
   logic              readout_done;
   logic [ADDR_W-1:0] rd_addr;
   sample_t           rd_data;
   acq_state_e        acq_state;
   logic [ADDR_W-1:0] trig_addr;
   evcount_t          event_count;

   logic [31:0]       rng_state = 32'hfe19;
   sample_t           script_q[$];
   int                cycle_count = 0;

   // Reference model state
   int                m_cnt;
   int                m_acc;
   sample_t           m_first;
   logic              m_valid;
   sample_t           m_dsample;
   logic              m_armed;
   int                m_run;
   logic              m_trig;
   acq_state_e        m_state;
   int                m_seg;
   logic [ADDR_W-1:0] m_wptr;
   logic [ADDR_W-1:0] m_trig_addr;
   evcount_t          m_events;
   sample_t           m_mem [DEPTH];
   logic [DEPTH-1:0]  m_written = '0;

   always #2 lvds_clk_slow_clkin = ~lvds_clk_slow_clkin;

   scope_top #(.ADDR_W(ADDR_W)) i_dut (.*);

   function automatic logic [31:0] xorshift(logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
      fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   // Scripted samples first, otherwise noise that stays between the thresholds
   always @(negedge lvds_clk_slow_clkin) begin
      if (script_q.size() > 0) begin
         adc_sample = script_q.pop_front();
      end else begin
         rng_state  = xorshift(rng_state);
         adc_sample = sample_t'(int'(rng_state % 32'd301) - 150);
      end
   end

   always @(posedge lvds_clk_slow_clkin) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   always @(posedge lvds_clk_slow_clkin) begin : ref_model
      int         n;
      int         mask;
      int         pos;
      int         acc_v;
      int         run_v;
      logic       armed_v;
      logic       arm_c;
      logic       run_c;
      logic       wr;
      int         seg_v;
      acq_state_e st_v;
      if (!rst_n) begin
         m_cnt    <= 0;
         m_valid  <= 1'b0;
         m_armed  <= 1'b0;
         m_run    <= 0;
         m_trig   <= 1'b0;
         m_state  <= acq_idle;
         m_seg    <= 0;
         m_wptr   <= '0;
         m_trig_addr <= '0;
         m_events <= '0;
      end else begin
         // Groups of 2^n inputs counted from the first clock after reset
         n     = (int'(downsample) > DS_MAX) ? DS_MAX : int'(downsample);
         mask  = (1 << n) - 1;
         pos   = m_cnt & mask;
         acc_v = (pos == 0) ? int'(adc_sample) : m_acc + int'(adc_sample);
         m_cnt <= m_cnt + 1;
         m_acc <= acc_v;
         if (pos == 0) begin
            m_first <= adc_sample;
         end
         m_valid <= (pos == mask);
         if (pos == mask) begin
            m_dsample <= highres ? sample_t'(acc_v >>> n) : ((pos == 0) ? adc_sample : m_first);
         end
         // Hysteresis: arm beyond one threshold, count runs beyond the other
         armed_v = m_armed;
         run_v   = m_run;
         m_trig  <= 1'b0;
         arm_c = (trig_type == trig_rising) ? (m_dsample <= lower_thresh)
                                            : (m_dsample >= upper_thresh);
         run_c = (trig_type == trig_rising) ? (m_dsample >= upper_thresh)
                                            : (m_dsample <= lower_thresh);
         if (m_state != acq_armed) begin
            armed_v = 1'b0;
            run_v   = 0;
         end else if (m_valid && !armed_v) begin
            armed_v = arm_c;
         end else if (m_valid && run_c) begin
            run_v = run_v + 1;
            if (run_v >= ((trig_tot == 8'd0) ? 1 : int'(trig_tot))) begin
               m_trig  <= 1'b1;
               armed_v = 1'b0;
               run_v   = 0;
            end
         end else if (m_valid) begin
            run_v = 0;
         end
         m_armed <= armed_v;
         m_run   <= run_v;
         // Acquisition sequence counted in written samples
         st_v  = m_state;
         seg_v = m_seg;
         wr    = m_valid && (m_state inside {acq_prefill, acq_armed, acq_postfill});
         case (m_state)
            acq_idle: begin
               if (arm) begin
                  st_v  = acq_prefill;
                  seg_v = 0;
               end
            end
            acq_prefill: begin
               seg_v = seg_v + int'(wr);
               if (seg_v == int'(pre_length)) begin
                  st_v  = acq_armed;
                  seg_v = 0;
               end
            end
            acq_armed: begin
               if (m_trig) begin
                  m_trig_addr <= m_wptr - ADDR_W'(1);
                  m_events    <= m_events + 32'd1;
                  wr    = wr && (post_length != '0);
                  seg_v = int'(wr);
                  st_v  = (seg_v == int'(post_length)) ? acq_done : acq_postfill;
               end
            end
            acq_postfill: begin
               seg_v = seg_v + int'(wr);
               if (seg_v == int'(post_length)) begin
                  st_v = acq_done;
               end
            end
            default: begin
               if (readout_done) begin
                  st_v = acq_idle;
               end
            end
         endcase
         m_state <= st_v;
         m_seg   <= seg_v;
         if (wr) begin
            m_mem[m_wptr]     <= m_dsample;
            m_written[m_wptr] <= 1'b1;
            m_wptr            <= m_wptr + ADDR_W'(1);
         end
      end
   end

   a_state: assert property (@(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      acq_state == m_state)
      else value_error("acq_state", 32'($sampled(acq_state)), 32'($sampled(m_state)));

   a_trig_addr: assert property (@(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      trig_addr == m_trig_addr)
      else value_error("trig_addr", 32'($sampled(trig_addr)), 32'($sampled(m_trig_addr)));

   a_events: assert property (@(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      event_count == m_events)
      else value_error("event_count", $sampled(event_count), $sampled(m_events));

   // Called right after a falling edge, data is back one cycle later
   task automatic read_word(input logic [ADDR_W-1:0] addr, output sample_t data);
      rd_addr = addr;
      @(negedge lvds_clk_slow_clkin);
      data = rd_data;
   endtask

   task automatic wait_for_state(acq_state_e target);
      while (acq_state != target) begin
         @(negedge lvds_clk_slow_clkin);
      end
   endtask

   task automatic start_acquisition(int pre, int post);
      pre_length  = ADDR_W'(pre);
      post_length = ADDR_W'(post);
      arm = 1'b1;
      @(negedge lvds_clk_slow_clkin);
      arm = 1'b0;
      wait_for_state(acq_armed);
   endtask

   // Record plus the word after it, which keeps whatever was there before
   task automatic check_record(int pre, int post);
      logic [ADDR_W-1:0] addr;
      sample_t           data;
      for (int off = -pre; off <= post + 1; off++) begin
         addr = trig_addr + ADDR_W'(off);
         read_word(addr, data);
         if (m_written[addr]) begin
            assert (data == m_mem[addr])
               else value_error($sformatf("rd_data[0x%0h]", addr), 32'(data), 32'(m_mem[addr]));
         end
      end
   endtask

   task automatic check_trigger_sample(sample_t expected, evcount_t events);
      sample_t data;
      assert (event_count == events) else value_error("event_count", event_count, events);
      read_word(trig_addr, data);
      assert (data == expected) else value_error("rd_data", 32'(data), 32'(expected));
      assert (data == m_mem[m_trig_addr])
         else value_error("rd_data", 32'(data), 32'(m_mem[m_trig_addr]));
   endtask

   task automatic finish_readout();
      readout_done = 1'b1;
      @(negedge lvds_clk_slow_clkin);
      readout_done = 1'b0;
      assert (acq_state == acq_idle) else value_error("acq_state", 32'(acq_state), 32'(acq_idle));
   endtask

   initial begin
      rst_n        = 1'b0;
      adc_sample   = '0;
      downsample   = '0;
      highres      = 1'b0;
      lower_thresh = sample_t'(-200);
      upper_thresh = sample_t'(200);
      trig_type    = trig_rising;
      trig_tot     = 8'd1;
      pre_length   = '0;
      post_length  = '0;
      arm          = 1'b0;
      readout_done = 1'b0;
      rd_addr      = '0;
      repeat (3) @(posedge lvds_clk_slow_clkin);
      @(negedge lvds_clk_slow_clkin);
      rst_n = 1'b1;
      @(negedge lvds_clk_slow_clkin);
      assert (acq_state == acq_idle) else value_error("acq_state", 32'(acq_state), 32'(acq_idle));
      assert (event_count == '0) else value_error("event_count", event_count, 32'd0);
      assert (trig_addr == '0) else value_error("trig_addr", 32'(trig_addr), 32'd0);

      // Full rate, rising edge with a one-sample threshold crossing
      start_acquisition(16, 20);
      script_q.push_back(sample_t'(-250));
      script_q.push_back(sample_t'(0));
      script_q.push_back(sample_t'(260));
      wait_for_state(acq_done);
      check_trigger_sample(sample_t'(260), 32'd1);
      check_record(16, 20);
      arm = 1'b1;
      @(negedge lvds_clk_slow_clkin);
      arm = 1'b0;
      assert (acq_state == acq_done) else value_error("acq_state", 32'(acq_state), 32'(acq_done));
      finish_readout();

      // Average of four on a ramp through both thresholds
      downsample = ds_t'(2);
      highres    = 1'b1;
      start_acquisition(24, 30);
      repeat (8) begin
         script_q.push_back(sample_t'(-400));
      end
      for (int v = -400; v <= 400; v += 100) begin
         script_q.push_back(sample_t'(v));
      end
      repeat (4) begin
         script_q.push_back(sample_t'(400));
      end
      wait_for_state(acq_done);
      check_trigger_sample(m_mem[m_trig_addr], 32'd2);
      check_record(24, 30);
      finish_readout();

      // Falling edge, a two-sample excursion is too short for three
      downsample = '0;
      highres    = 1'b0;
      trig_type  = trig_falling;
      trig_tot   = 8'd3;
      start_acquisition(10, 12);
      script_q.push_back(sample_t'(250));
      script_q.push_back(sample_t'(-300));
      script_q.push_back(sample_t'(-301));
      script_q.push_back(sample_t'(0));
      script_q.push_back(sample_t'(-310));
      script_q.push_back(sample_t'(-311));
      script_q.push_back(sample_t'(-312));
      wait_for_state(acq_done);
      check_trigger_sample(sample_t'(-312), 32'd3);
      check_record(10, 12);
      finish_readout();

      $display("Test passed");
      $finish;
   end

endmodule

/* scope_capture.f */
rtl/scope_pkg.sv
rtl/trig_cfg_if.sv
rtl/sample_downsampler.sv
rtl/trigger_detector.sv
rtl/acq_controller.sv
rtl/sample_ram.sv
rtl/scope_top.sv
dv/scope_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the scope capture testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module scope_tb -f scope_capture.f \
   && ./obj_dir/Vscope_tb | tee sim.log
grep -qx "Test passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
